// File: source/lsu_pkg.sv
package lsu_pkg;

  // one bank word and one stream beat
  localparam int WORD_W = 64;
  localparam int WORDS_PER_BEAT = 8;
  localparam int BEAT_W = WORD_W * WORDS_PER_BEAT;

  // bank count, also used as the cyclic factor
  localparam int NUM_BANKS = 4;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [BEAT_W-1:0] beat_t;
  typedef logic [$clog2(NUM_BANKS)-1:0] bank_sel_t;

  typedef enum logic [1:0] {
    MODE_IDLE  = 2'd0,
    // stream to RAM
    MODE_STORE = 2'd1,
    // RAM to stream
    MODE_LOAD  = 2'd2
  } lsu_mode_t;

endpackage

// File: source/beat_unpacker.sv
module beat_unpacker import lsu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  beat_t in_data,
  input  logic  in_valid,
  output logic  in_ready,
  output word_t word,
  output logic  word_valid,
  input  logic  word_ready
);

  localparam int CNT_W = $clog2(WORDS_PER_BEAT);

  beat_t            beat_q;
  logic [CNT_W-1:0] cnt;
  logic             full;

  // word_ready is only high while a store runs, so no beat is taken outside one
  assign in_ready   = !full && word_ready;
  assign word       = beat_q[WORD_W-1:0];
  assign word_valid = full;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
      cnt  <= '0;
    end else if (in_valid && in_ready) begin
      full <= 1'b1;
      cnt  <= '0;
    end else if (word_valid && word_ready) begin
      cnt <= cnt + 1'b1;
      if (cnt == CNT_W'(WORDS_PER_BEAT - 1)) begin
        full <= 1'b0;
      end
    end
  end

  // lowest word leaves first
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      beat_q <= in_data;
    end else if (word_valid && word_ready) begin
      beat_q <= beat_q >> WORD_W;
    end
  end

endmodule

// File: source/beat_packer.sv
module beat_packer import lsu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  word_t word,
  input  logic  word_valid,
  output logic  word_ready,
  output beat_t out_data,
  output logic  out_valid,
  input  logic  out_ready,
  output logic  beat_done
);

  localparam int CNT_W = $clog2(WORDS_PER_BEAT);

  beat_t            beat_q;
  logic [CNT_W-1:0] cnt;
  logic             full;

  assign word_ready = !full;
  assign out_data   = beat_q;
  assign out_valid  = full;
  assign beat_done  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
      cnt  <= '0;
    end else if (beat_done) begin
      full <= 1'b0;
    end else if (word_valid && word_ready) begin
      cnt <= cnt + 1'b1;
      // eighth word completes the beat
      if (cnt == CNT_W'(WORDS_PER_BEAT - 1)) begin
        full <= 1'b1;
      end
    end
  end

  // new words enter at the top, so word 0 ends up in the low bits
  always_ff @(posedge clk) begin
    if (word_valid && word_ready) begin
      beat_q <= {word, beat_q[BEAT_W-1:WORD_W]};
    end
  end

endmodule

// File: source/bank_addr_gen.sv
module bank_addr_gen import lsu_pkg::*; #(
  parameter int ADDR_W = 12
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  logic [31:0]       len,
  input  logic [31:0]       block_factor,
  input  logic [31:0]       addr_offset,
  input  logic              step,
  output bank_sel_t         bank_sel,
  output logic [ADDR_W-1:0] bank_addr,
  output logic              last
);

  logic [31:0]       len_q;
  logic [31:0]       bf_q;
  logic [31:0]       idx;
  logic [31:0]       blk;
  bank_sel_t         bank;
  logic [ADDR_W-1:0] row;

  assign bank_sel  = bank;
  assign bank_addr = row + blk[ADDR_W-1:0];
  assign last      = (idx == len_q - 32'd1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      len_q <= '0;
      bf_q  <= 32'd1;
      idx   <= '0;
      blk   <= '0;
      bank  <= '0;
      row   <= '0;
    end else if (start) begin
      len_q <= len;
      bf_q  <= block_factor;
      idx   <= '0;
      blk   <= '0;
      bank  <= '0;
      row   <= addr_offset[ADDR_W-1:0];
    end else if (step) begin
      idx <= idx + 32'd1;
      if (blk == bf_q - 32'd1) begin
        blk <= '0;
        // after the fourth block move down one row of blocks
        if (bank == bank_sel_t'(NUM_BANKS - 1)) begin
          bank <= '0;
          row  <= row + bf_q[ADDR_W-1:0];
        end else begin
          bank <= bank + 1'b1;
        end
      end else begin
        blk <= blk + 32'd1;
      end
    end
  end

endmodule

// File: source/result_fifo.sv
module result_fifo import lsu_pkg::*; #(
  parameter int RAM_READ_LATENCY = 2
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  word_t                                 enq_data,
  input  logic                                  enq_valid,
  output logic                                  enq_ready,
  output word_t                                 deq_data,
  output logic                                  deq_valid,
  input  logic                                  deq_ready,
  output logic [$clog2(RAM_READ_LATENCY+1)-1:0] count
);

  localparam int DEPTH = RAM_READ_LATENCY;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  word_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             enq_fire;
  logic             deq_fire;

  assign enq_ready = (count < DEPTH);
  assign deq_valid = (count != 0);
  assign deq_data  = mem[rd_ptr];
  assign enq_fire  = enq_valid && enq_ready;
  assign deq_fire  = deq_valid && deq_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq_fire) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (deq_fire) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + enq_fire - deq_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (enq_fire) begin
      mem[wr_ptr] <= enq_data;
    end
  end

endmodule

// File: source/lsu_ctrl.sv
module lsu_ctrl import lsu_pkg::*; #(
  parameter int ADDR_W = 12,
  parameter int RAM_READ_LATENCY = 2
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  start,
  input  lsu_mode_t                             mode,
  input  word_t                                 word,
  input  logic                                  word_valid,
  output logic                                  word_ready,
  output logic                                  step,
  input  bank_sel_t                             bank_sel,
  input  logic [ADDR_W-1:0]                     cur_addr,
  input  logic                                  last,
  output logic [NUM_BANKS-1:0][ADDR_W-1:0]      bank_addr,
  output word_t [NUM_BANKS-1:0]                 bank_d,
  output logic [NUM_BANKS-1:0]                  bank_ce,
  output logic [NUM_BANKS-1:0]                  bank_we,
  input  word_t [NUM_BANKS-1:0]                 bank_q,
  output word_t                                 fifo_data,
  output logic                                  fifo_valid,
  input  logic                                  fifo_ready,
  input  logic [$clog2(RAM_READ_LATENCY+1)-1:0] fifo_count,
  input  logic                                  beat_done,
  output logic                                  done
);

  localparam int LAT    = RAM_READ_LATENCY;
  localparam int CNT_W  = $clog2(2 * LAT + 2);
  localparam int PEND_W = $clog2(LAT + 2 * WORDS_PER_BEAT + 2);

  typedef enum logic [1:0] {S_IDLE, S_RUN, S_DRAIN, S_DONE} state_t;

  state_t               state;
  lsu_mode_t            mode_q;
  logic                 word_fire;
  logic                 rd_issue;
  logic                 rd_port;
  logic [NUM_BANKS-1:0] bank_onehot;
  bank_sel_t            port_sel;
  logic [LAT-1:0]       vld_sh;
  bank_sel_t            sel_sh [LAT];
  logic [CNT_W-1:0]     inflight;
  // words read but not yet sent out in a beat
  logic [PEND_W-1:0]    pend;

  assign word_ready  = (state == S_RUN) && (mode_q == MODE_STORE);
  assign word_fire   = word_valid && word_ready;
  assign bank_onehot = {{(NUM_BANKS-1){1'b0}}, 1'b1} << bank_sel;
  assign rd_port     = |bank_ce && !(|bank_we);
  assign done        = (state == S_DONE);

  // reads at the ports plus reads in the latency pipe
  always_comb begin
    inflight = CNT_W'(rd_port);
    for (int i = 0; i < LAT; i++) begin
      inflight = inflight + CNT_W'(vld_sh[i]);
    end
  end

  // throttle so the FIFO always has room for every read in flight
  assign rd_issue = (state == S_RUN) && (mode_q == MODE_LOAD) && fifo_ready &&
                    (inflight + fifo_count < LAT);
  assign step     = word_fire || rd_issue;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= S_IDLE;
      mode_q <= MODE_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (start && mode != MODE_IDLE) begin
            mode_q <= mode;
            state  <= S_RUN;
          end
        end
        S_RUN: begin
          if (step && last) begin
            state <= S_DRAIN;
          end
        end
        S_DRAIN: begin
          // store waits one cycle for the last write at the ports
          if (mode_q == MODE_STORE) begin
            state <= S_DONE;
          end else if (beat_done && pend == PEND_W'(WORDS_PER_BEAT)) begin
            state <= S_DONE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend <= '0;
    end else begin
      pend <= pend + PEND_W'(rd_issue) - (beat_done ? PEND_W'(WORDS_PER_BEAT) : '0);
    end
  end

  // registered bank ports, one cycle behind the word transfer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bank_ce <= '0;
      bank_we <= '0;
    end else begin
      bank_ce <= step ? bank_onehot : '0;
      bank_we <= word_fire ? bank_onehot : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (step) begin
      bank_addr <= {NUM_BANKS{cur_addr}};
      bank_d    <= {NUM_BANKS{word}};
      port_sel  <= bank_sel;
    end
  end

  // read valid and bank select follow the RAM latency
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_sh <= '0;
    end else begin
      vld_sh[0] <= rd_port;
      for (int i = 1; i < LAT; i++) begin
        vld_sh[i] <= vld_sh[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    sel_sh[0] <= port_sel;
    for (int i = 1; i < LAT; i++) begin
      sel_sh[i] <= sel_sh[i-1];
    end
  end

  assign fifo_valid = vld_sh[LAT-1];
  assign fifo_data  = bank_q[sel_sh[LAT-1]];

endmodule

// File: source/lsu_top.sv
module lsu_top import lsu_pkg::*; #(
  parameter int ADDR_W = 12,
  parameter int RAM_READ_LATENCY = 2
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             start,
  input  lsu_mode_t                        mode,
  input  logic [31:0]                      len,
  input  logic [31:0]                      block_factor,
  input  logic [31:0]                      addr_offset,
  output logic                             done,
  input  beat_t                            in_data,
  input  logic                             in_valid,
  output logic                             in_ready,
  output beat_t                            out_data,
  output logic                             out_valid,
  input  logic                             out_ready,
  output logic [NUM_BANKS-1:0][ADDR_W-1:0] bank_addr,
  output word_t [NUM_BANKS-1:0]            bank_d,
  output logic [NUM_BANKS-1:0]             bank_ce,
  output logic [NUM_BANKS-1:0]             bank_we,
  input  word_t [NUM_BANKS-1:0]            bank_q
);

  localparam int FCNT_W = $clog2(RAM_READ_LATENCY + 1);

  word_t             st_word;
  logic              st_valid;
  logic              st_ready;
  logic              step;
  bank_sel_t         bank_sel;
  logic [ADDR_W-1:0] cur_addr;
  logic              last;
  word_t             fifo_data;
  logic              fifo_valid;
  logic              fifo_ready;
  logic [FCNT_W-1:0] fifo_count;
  word_t             ld_word;
  logic              ld_valid;
  logic              ld_ready;
  logic              beat_done;

  beat_unpacker u_unpacker (
    .clk(clk), .rst_n(rst_n),
    .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
    .word(st_word), .word_valid(st_valid), .word_ready(st_ready)
  );

  bank_addr_gen #(.ADDR_W(ADDR_W)) u_addr_gen (
    .clk(clk), .rst_n(rst_n), .start(start),
    .len(len), .block_factor(block_factor), .addr_offset(addr_offset),
    .step(step), .bank_sel(bank_sel), .bank_addr(cur_addr), .last(last)
  );

  lsu_ctrl #(.ADDR_W(ADDR_W), .RAM_READ_LATENCY(RAM_READ_LATENCY)) u_ctrl (
    .clk(clk), .rst_n(rst_n), .start(start), .mode(mode),
    .word(st_word), .word_valid(st_valid), .word_ready(st_ready),
    .step(step), .bank_sel(bank_sel), .cur_addr(cur_addr), .last(last),
    .bank_addr(bank_addr), .bank_d(bank_d), .bank_ce(bank_ce), .bank_we(bank_we),
    .bank_q(bank_q),
    .fifo_data(fifo_data), .fifo_valid(fifo_valid), .fifo_ready(fifo_ready),
    .fifo_count(fifo_count), .beat_done(beat_done), .done(done)
  );

  result_fifo #(.RAM_READ_LATENCY(RAM_READ_LATENCY)) u_fifo (
    .clk(clk), .rst_n(rst_n),
    .enq_data(fifo_data), .enq_valid(fifo_valid), .enq_ready(fifo_ready),
    .deq_data(ld_word), .deq_valid(ld_valid), .deq_ready(ld_ready),
    .count(fifo_count)
  );

  beat_packer u_packer (
    .clk(clk), .rst_n(rst_n),
    .word(ld_word), .word_valid(ld_valid), .word_ready(ld_ready),
    .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready),
    .beat_done(beat_done)
  );

endmodule

// File: tests/lsu_assert.sv
module lsu_assert import lsu_pkg::*; (
  input logic                 clk,
  input logic                 rst_n,
  input logic [NUM_BANKS-1:0] bank_ce,
  input logic [NUM_BANKS-1:0] bank_we,
  input logic                 done,
  input beat_t                out_data,
  input logic                 out_valid,
  input logic                 out_ready
);

  a_one_bank: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(bank_ce))
    else $error("more than one bank enabled in a cycle");

  a_we_has_ce: assert property (@(posedge clk) disable iff (!rst_n) (bank_we & ~bank_ce) == '0)
    else $error("bank write enable without chip enable");

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done held longer than one cycle");

  // a waiting beat must not move or vanish
  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("output beat dropped or changed before transfer");

endmodule

bind lsu_top lsu_assert u_assert (
  .clk(clk), .rst_n(rst_n), .bank_ce(bank_ce), .bank_we(bank_we), .done(done),
  .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
);

// File: tests/lsu_checker.sv
module lsu_checker import lsu_pkg::*; #(
  parameter int ADDR_W = 12
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             start,
  input  lsu_mode_t                        mode,
  input  logic [31:0]                      len,
  input  logic [31:0]                      block_factor,
  input  logic [31:0]                      addr_offset,
  input  logic [127:0]                     test_name,
  input  beat_t                            in_data,
  input  logic                             in_valid,
  input  logic                             in_ready,
  input  beat_t                            out_data,
  input  logic                             out_valid,
  input  logic                             out_ready,
  input  logic [NUM_BANKS-1:0][ADDR_W-1:0] bank_addr,
  input  word_t [NUM_BANKS-1:0]            bank_d,
  input  logic [NUM_BANKS-1:0]             bank_ce,
  input  logic [NUM_BANKS-1:0]             bank_we,
  input  logic                             done,
  output int                               pass_count,
  output int                               fail_count
);

  // reference copy of the banks, filled from the placement rule
  word_t        model [NUM_BANKS][2**ADDR_W];
  word_t        in_words [$];
  logic [127:0] name_q;
  lsu_mode_t    mode_q;
  int           len_q;
  int           bf_q;
  int           off_q;
  int           idx;
  int           bad;
  logic         active;
  logic         seen_start;
  logic [10:0]  reset_act;
  logic [63:0]  what;
  int           bad_idx;
  word_t        exp_v;
  word_t        act_v;

  function automatic int place_bank(input int i);
    return (i / bf_q) % NUM_BANKS;
  endfunction

  function automatic int place_addr(input int i);
    return (off_q + (i / (NUM_BANKS * bf_q)) * bf_q + i % bf_q) % (2 ** ADDR_W);
  endfunction

  // keeps the first mismatch of the running test
  task automatic mismatch(input logic [63:0] field, input word_t e, input word_t a);
    if (bad == 0) begin
      what    = field;
      bad_idx = idx;
      exp_v   = e;
      act_v   = a;
    end
    bad++;
  endtask

  task automatic check_write();
    int    b;
    word_t w;
    b = 0;
    for (int k = 0; k < NUM_BANKS; k++) begin
      if (bank_we[k]) begin
        b = k;
      end
    end
    if (in_words.size() == 0) begin
      mismatch("count", word_t'(len_q), word_t'(idx + 1));
    end else begin
      w = in_words.pop_front();
      if (b != place_bank(idx)) begin
        mismatch("bank", word_t'(place_bank(idx)), word_t'(b));
      end else if (bank_addr[b] != ADDR_W'(place_addr(idx))) begin
        mismatch("addr", word_t'(place_addr(idx)), word_t'(bank_addr[b]));
      end else if (bank_d[b] != w) begin
        mismatch("data", w, bank_d[b]);
      end
      model[place_bank(idx)][place_addr(idx)] = w;
    end
    idx++;
  endtask

  task automatic check_beat();
    word_t w;
    for (int k = 0; k < WORDS_PER_BEAT; k++) begin
      w = out_data[k*WORD_W +: WORD_W];
      if (idx >= len_q) begin
        mismatch("count", word_t'(len_q), word_t'(idx + 1));
      end else if (w != model[place_bank(idx)][place_addr(idx)]) begin
        mismatch("data", model[place_bank(idx)][place_addr(idx)], w);
      end
      idx++;
    end
  endtask

  task automatic finish_test();
    if (bad == 0 && idx != len_q) begin
      mismatch("count", word_t'(len_q), word_t'(idx));
    end
    if (bad == 0) begin
      pass_count++;
      $display("%0s passed", name_q);
    end else begin
      fail_count++;
      $display("FAILED %0s word %0d %0s expected %h actual %h",
               name_q, bad_idx, what, exp_v, act_v);
    end
    active = 1'b0;
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      active     = 1'b0;
      seen_start = 1'b0;
      reset_act  = '0;
      pass_count = 0;
      fail_count = 0;
    end else begin
      // idle outputs before the first run
      if (!seen_start && reset_act == '0) begin
        reset_act = {in_ready, out_valid, done, bank_ce, bank_we};
      end
      if (start) begin
        if (!seen_start) begin
          if (reset_act == '0) begin
            pass_count++;
            $display("reset_state passed");
          end else begin
            fail_count++;
            $display("FAILED reset_state expected %h actual %h", 11'h0, reset_act);
          end
        end
        seen_start = 1'b1;
        active     = 1'b1;
        name_q     = test_name;
        mode_q     = mode;
        len_q      = int'(len);
        bf_q       = int'(block_factor);
        off_q      = int'(addr_offset);
        idx        = 0;
        bad        = 0;
        in_words.delete();
      end else if (active) begin
        if (mode_q == MODE_STORE && in_valid && in_ready) begin
          for (int k = 0; k < WORDS_PER_BEAT; k++) begin
            in_words.push_back(in_data[k*WORD_W +: WORD_W]);
          end
        end
        if (|bank_we) begin
          check_write();
        end
        if (mode_q == MODE_LOAD && out_valid && out_ready) begin
          check_beat();
        end
        if (done) begin
          finish_test();
        end
      end else if (done) begin
        fail_count++;
        $display("%0s: done pulsed again after the run had ended", name_q);
      end
    end
  end

endmodule

// File: tests/tb_lsu.sv
module tb_lsu import lsu_pkg::*; ();

  localparam int ADDR_W      = 12;
  localparam int LAT         = 2;
  localparam int CYCLE_LIMIT = 2000;

  logic                             clk;
  logic                             rst_n;
  logic                             start;
  lsu_mode_t                        mode;
  logic [31:0]                      len;
  logic [31:0]                      block_factor;
  logic [31:0]                      addr_offset;
  logic                             done;
  beat_t                            in_data;
  logic                             in_valid;
  logic                             in_ready;
  beat_t                            out_data;
  logic                             out_valid;
  logic                             out_ready;
  logic [NUM_BANKS-1:0][ADDR_W-1:0] bank_addr;
  word_t [NUM_BANKS-1:0]            bank_d;
  logic [NUM_BANKS-1:0]             bank_ce;
  logic [NUM_BANKS-1:0]             bank_we;
  word_t [NUM_BANKS-1:0]            bank_q;
  logic [127:0]                     test_name;
  int                               pass_count;
  int                               fail_count;
  integer                           seed;
  logic                             run_broken;
  word_t                            ram [NUM_BANKS][2**ADDR_W];
  word_t                            rd_pipe [NUM_BANKS][LAT];

  lsu_top #(.ADDR_W(ADDR_W), .RAM_READ_LATENCY(LAT)) UUT (
    .clk(clk), .rst_n(rst_n), .start(start), .mode(mode), .len(len),
    .block_factor(block_factor), .addr_offset(addr_offset), .done(done),
    .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
    .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready),
    .bank_addr(bank_addr), .bank_d(bank_d), .bank_ce(bank_ce), .bank_we(bank_we),
    .bank_q(bank_q)
  );

  lsu_checker #(.ADDR_W(ADDR_W)) u_checker (
    .clk(clk), .rst_n(rst_n), .start(start), .mode(mode), .len(len),
    .block_factor(block_factor), .addr_offset(addr_offset), .test_name(test_name),
    .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
    .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready),
    .bank_addr(bank_addr), .bank_d(bank_d), .bank_ce(bank_ce), .bank_we(bank_we),
    .done(done), .pass_count(pass_count), .fail_count(fail_count)
  );

  always #50 clk = ~clk;

  // four single-port banks whose q appears LAT cycles after the read cycle
  always @(posedge clk) begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (bank_ce[b] && bank_we[b]) begin
        ram[b][bank_addr[b]] = bank_d[b];
      end else if (bank_ce[b]) begin
        rd_pipe[b][0] <= ram[b][bank_addr[b]];
      end
      for (int s = 1; s < LAT; s++) begin
        rd_pipe[b][s] <= rd_pipe[b][s-1];
      end
    end
  end

  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_q[b] = rd_pipe[b][LAT-1];
    end
  end

  function automatic logic roll(input int pct);
    return ((($random(seed)) & 32'h7fff_ffff) % 100) < pct;
  endfunction

  task automatic send_beats(input int n_words, input int stall);
    beat_t beat;
    int    cyc;
    for (int bt = 0; bt < n_words / WORDS_PER_BEAT && !run_broken; bt++) begin
      for (int k = 0; k < WORDS_PER_BEAT; k++) begin
        beat[k*WORD_W +: WORD_W] = {$random(seed), $random(seed)};
      end
      if (roll(stall)) begin
        @(negedge clk);
      end
      in_data  = beat;
      in_valid = 1'b1;
      cyc      = 0;
      while (!in_ready && !run_broken) begin
        @(negedge clk);
        cyc++;
        if (cyc > CYCLE_LIMIT) begin
          $display("timeout: input beat %0d of %0s was never accepted", bt, test_name);
          run_broken = 1'b1;
        end
      end
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  task automatic wait_done(input int stall, input logic is_load);
    int cyc;
    cyc = 0;
    while (!done && !run_broken) begin
      if (is_load) begin
        out_ready = !roll(stall);
      end
      @(negedge clk);
      cyc++;
      if (cyc > CYCLE_LIMIT) begin
        $display("timeout: no done pulse for %0s within %0d cycles", test_name, CYCLE_LIMIT);
        run_broken = 1'b1;
      end
    end
    out_ready = 1'b0;
    @(negedge clk);
  endtask

  initial begin
    string        line;
    logic [127:0] name;
    int           fd;
    int           m;
    int           n;
    int           bf;
    int           off;
    int           stall;
    seed         = 45;
    run_broken   = 1'b0;
    clk          = 1'b0;
    rst_n        = 1'b0;
    start        = 1'b0;
    mode         = MODE_IDLE;
    len          = '0;
    block_factor = 32'd1;
    addr_offset  = '0;
    in_data      = '0;
    in_valid     = 1'b0;
    out_ready    = 1'b0;
    test_name    = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int a = 0; a < 2**ADDR_W; a++) begin
        ram[b][a] = {32'(b) ^ 32'hc0de_0000, 32'(a)};
      end
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);
    fd = $fopen("tests/lsu_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/lsu_tests.txt");
      run_broken = 1'b1;
    end
    while (fd != 0 && !run_broken && $fgets(line, fd) != 0) begin
      if (line.len() > 1 && line[0] != "#" &&
          $sscanf(line, "%s %d %d %d %d %d", name, m, n, bf, off, stall) == 6) begin
        test_name    = name;
        mode         = lsu_mode_t'(m);
        len          = n;
        block_factor = bf;
        addr_offset  = off;
        start        = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (mode == MODE_STORE) begin
          send_beats(n, stall);
        end
        wait_done(stall, mode == MODE_LOAD);
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    repeat (4) @(negedge clk);
    $display("results: %0d passed, %0d failed", pass_count, fail_count);
    if (run_broken || fail_count != 0) begin
      $display("test failed");
    end else begin
      $display("test passed");
    end
    $finish;
  end

endmodule

// File: tests/lsu_tests.txt
# name mode(1 store, 2 load) len block_factor addr_offset stall_pct
# stall_pct is the chance of an in_valid gap (store) or out_ready low (load)
store_bf1 1 32 1 0 0
load_bf1 2 32 1 0 0
store_bf2 1 48 2 16 30
load_bf2 2 48 2 16 40
store_bf3 1 64 3 200 40
load_bf3 2 64 3 200 50

// File: sim.f
source/lsu_pkg.sv
source/beat_unpacker.sv
source/beat_packer.sv
source/bank_addr_gen.sv
source/result_fifo.sv
source/lsu_ctrl.sv
source/lsu_top.sv
tests/lsu_assert.sv
tests/lsu_checker.sv
tests/tb_lsu.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu -f sim.f -o tb_lsu_sim

# the verdict comes from the log, not from the exit status of the run
./obj_dir/tb_lsu_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
  exit 0
fi
exit 1
